//--- sim.f
hdl/blend_pkg.sv
hdl/pix_pair_if.sv
hdl/blend_regs.sv
hdl/pixel_fetch.sv
hdl/alpha_mix.sv
hdl/pixel_store.sv
hdl/alpha_blend.sv
dv/sram_model.sv
dv/tb_alpha_blend.sv

//--- dv/tb_alpha_blend.sv
`default_nettype none

module tb_alpha_blend
	import blend_pkg::*;
();

	logic              clk;
	logic              reset;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [apb_aw-1:0] paddr;
	logic [apb_dw-1:0] pwdata;
	logic [apb_dw-1:0] prdata;
	logic              pready;
	logic              pslverr;
	logic              rd_en;
	logic [addr_w-1:0] rd_addr;
	logic [pix_w-1:0]  rd_data;
	logic              wr_en;
	logic [addr_w-1:0] wr_addr;
	logic [pix_w-1:0]  wr_data;
	int                wr_seen;    // Writes since reset
	logic [addr_w-1:0] region_lo;  // Destination window of the current run
	logic [addr_w-1:0] region_hi;
	logic [apb_dw-1:0] rdata;
	logic              err;

	alpha_blend dut (
		.clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	sram_model sram (
		.clk(clk), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	always #4 clk = ~clk;  // Period 8

	always @(posedge clk)
	begin
		if (reset)
			wr_seen <= 0;
		else if (wr_en)
			wr_seen <= wr_seen + 1;
	end

	task automatic stop_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	// Any write must land inside the programmed destination window
	a_region: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> (wr_addr >= region_lo) && (wr_addr <= region_hi))
	else
	begin
		$display("FAIL region expected %h to %h actual %h", region_lo, region_hi, wr_addr);
		stop_run();
	end

	function automatic logic [pix_w-1:0] peek_word(input logic [addr_w-1:0] addr);
		return sram.mem[addr % $size(sram.mem)];
	endfunction

	task automatic poke_word(input logic [addr_w-1:0] addr, input logic [pix_w-1:0] data);
		sram.mem[addr % $size(sram.mem)] = data;
	endtask

	// Channel rule (a * alpha + b * (16 - alpha)) >> 4
	function automatic logic [pix_w-1:0] blend_word(input logic [pix_w-1:0] a,
		input logic [pix_w-1:0] b, input int al);
		logic [pix_w-1:0] res;
		int               ca;
		int               cb;
		for (int c = 0; c < 3; c++)
		begin
			ca = a[c*8 +: 8];
			cb = b[c*8 +: 8];
			res[c*8 +: 8] = 8'((ca * al + cb * (16 - al)) >> 4);
		end
		return res;
	endfunction

	task automatic apb_write(input logic [apb_aw-1:0] addr, input logic [apb_dw-1:0] data,
		output logic slverr);
		@(posedge clk);
		psel    <= 1'b1;  // Setup
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;  // Access
		@(negedge clk);
		slverr = pslverr;
		check_val("apb write pready", 32'h1, 32'(pready));
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [apb_aw-1:0] addr, output logic [apb_dw-1:0] data,
		output logic slverr);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data   = prdata;  // Sampled mid access cycle
		slverr = pslverr;
		check_val("apb read pready", 32'h1, 32'(pready));
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic run_blend(input string name, input logic [addr_w-1:0] a_base,
		input logic [addr_w-1:0] b_base, input logic [addr_w-1:0] d_base,
		input logic [cnt_w-1:0] n, input logic [alpha_w-1:0] al);
		logic [apb_dw-1:0] status;
		logic              slverr;
		logic [pix_w-1:0]  below;
		logic [pix_w-1:0]  above;
		int                polls;
		int                writes_before;
		int                writes_at_done;
		below     = peek_word(d_base - 1'b1);  // Neighbours of the window
		above     = peek_word(d_base + n);
		region_lo = d_base;
		region_hi = d_base + n - 1'b1;  // Below region_lo when n is 0
		apb_write(reg_src_a, apb_dw'(a_base), slverr);
		apb_write(reg_src_b, apb_dw'(b_base), slverr);
		apb_write(reg_dst, apb_dw'(d_base), slverr);
		apb_write(reg_count, apb_dw'(n), slverr);
		writes_before = wr_seen;
		apb_write(reg_ctrl, apb_dw'({al, 4'b0001}), slverr);
		status = '0;
		polls  = 0;
		while (!status[stat_done_bit] && (polls < 400))
		begin
			apb_read(reg_status, status, slverr);
			polls++;
		end
		writes_at_done = wr_seen;
		if (!status[stat_done_bit])
		begin
			$display("Timeout, %s never reported done", name);
			stop_run();
		end
		check_val({name, " writes at done"}, 32'(n), 32'(writes_at_done - writes_before));
		check_val({name, " status"}, 32'h2, status);  // Done set, busy clear
		check_val({name, " status pslverr"}, 32'h0, 32'(slverr));  // Mapped offset
		for (int k = 0; k < n; k++)
			check_val({name, " pixel"}, blend_word(peek_word(a_base + k),
				peek_word(b_base + k), al), peek_word(d_base + k));
		check_val({name, " word below"}, below, peek_word(d_base - 1'b1));
		check_val({name, " word above"}, above, peek_word(d_base + n));
	endtask

	initial
	begin
		logic [9:0] a10;
		clk       = 1'b0;
		reset     = 1'b1;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		region_lo = '0;
		region_hi = '0;
		void'($urandom(97360));
		for (int i = 0; i < $size(sram.mem); i++)
		begin
			a10 = i[9:0];
			poke_word(i, {4'hA, a10, ~a10});  // Pattern from the whole address
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		apb_write(reg_src_a, 32'h123456, err);  // Register readback
		apb_write(reg_src_b, 32'h00ABCD, err);
		apb_write(reg_dst, 32'h3FFFFF, err);
		apb_write(reg_count, 32'h1234, err);
		apb_write(reg_ctrl, 32'h0B0, err);
		apb_read(reg_src_a, rdata, err);
		check_val("readback src_a", 32'h123456, rdata);
		apb_read(reg_src_b, rdata, err);
		check_val("readback src_b", 32'h00ABCD, rdata);
		apb_read(reg_dst, rdata, err);
		check_val("readback dst", 32'h3FFFFF, rdata);
		apb_read(reg_count, rdata, err);
		check_val("readback count", 32'h1234, rdata);
		apb_read(reg_ctrl, rdata, err);
		check_val("readback alpha", 32'h0B0, rdata);

		apb_read(8'h20, rdata, err);  // Unmapped offset
		check_val("unmapped read pslverr", 32'h1, 32'(err));
		check_val("unmapped read data", 32'h0, rdata);
		apb_write(8'h20, 32'hFFFF_FFFF, err);
		check_val("unmapped write pslverr", 32'h1, 32'(err));

		for (int k = 0; k < 20; k++)
		begin
			poke_word(24'h100 + k, pix_w'($urandom));
			poke_word(24'h200 + k, pix_w'($urandom));
		end
		run_blend("random blend", 24'h100, 24'h200, 24'h300, 16'd20, alpha_w'($urandom % 16));

		poke_word(24'h120, 24'hFFFFFF);  // Extreme channels first
		poke_word(24'h220, 24'h000000);
		poke_word(24'h121, 24'h000000);
		poke_word(24'h221, 24'hFFFFFF);
		for (int k = 2; k < 8; k++)
		begin
			poke_word(24'h120 + k, pix_w'($urandom));
			poke_word(24'h220 + k, pix_w'($urandom));
		end
		run_blend("alpha 0", 24'h120, 24'h220, 24'h340, 16'd8, 4'd0);
		for (int k = 0; k < 8; k++)
			check_val("alpha 0 copies b", peek_word(24'h220 + k), peek_word(24'h340 + k));
		run_blend("alpha 15", 24'h120, 24'h220, 24'h380, 16'd8, 4'd15);

		run_blend("zero count", 24'h100, 24'h200, 24'h3C0, 16'd0, 4'd7);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/sram_model.sv
`default_nettype none

// Two-port SRAM, read data valid one cycle after rd_en
module sram_model
	import blend_pkg::*;
#(
	parameter int mem_aw = 10               // Words kept, upper address bits ignored
)
(
	input  logic              clk,
	input  logic              rd_en,
	input  logic [addr_w-1:0] rd_addr,
	output logic [pix_w-1:0]  rd_data,
	input  logic              wr_en,
	input  logic [addr_w-1:0] wr_addr,
	input  logic [pix_w-1:0]  wr_data
);

	logic [pix_w-1:0] mem [0:(1 << mem_aw)-1];  // Backdoor array for the testbench

	always @(posedge clk)
	begin
		if (rd_en)
			rd_data <= mem[rd_addr[mem_aw-1:0]];  // Registered read
		if (wr_en)
			mem[wr_addr[mem_aw-1:0]] <= wr_data;
	end

endmodule

`default_nettype wire

//--- hdl/alpha_blend.sv
`default_nettype none

module alpha_blend
	import blend_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [apb_aw-1:0] paddr,
	input  logic [apb_dw-1:0] pwdata,
	output logic [apb_dw-1:0] prdata,
	output logic              pready,
	output logic              pslverr,
	output logic              rd_en,
	output logic [addr_w-1:0] rd_addr,
	input  logic [pix_w-1:0]  rd_data,
	output logic              wr_en,
	output logic [addr_w-1:0] wr_addr,
	output logic [pix_w-1:0]  wr_data
);

	logic               start;       // Run kick-off pulse
	logic [alpha_w-1:0] alpha;
	logic [addr_w-1:0]  src_a;
	logic [addr_w-1:0]  src_b;
	logic [addr_w-1:0]  dst;
	logic [cnt_w-1:0]   count;
	logic               done_pulse;  // Store reports the last write
	logic               out_valid;   // Mix to store results
	logic               out_last;
	logic [cnt_w-1:0]   out_index;
	pixel_t             out_pix;

	pix_pair_if pair ();  // Fetch to mix

	blend_regs u_regs (
		.clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .done_pulse(done_pulse), .start(start), .alpha(alpha),
		.src_a(src_a), .src_b(src_b), .dst(dst), .count(count)
	);

	pixel_fetch u_fetch (
		.clk(clk), .reset(reset), .start(start), .src_a(src_a), .src_b(src_b),
		.count(count), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.pair(pair.src)
	);

	alpha_mix u_mix (
		.clk(clk), .reset(reset), .alpha(alpha), .pair(pair.dst),
		.out_valid(out_valid), .out_last(out_last), .out_index(out_index),
		.out_pix(out_pix)
	);

	pixel_store u_store (
		.clk(clk), .reset(reset), .dst(dst), .out_valid(out_valid),
		.out_last(out_last), .out_index(out_index), .out_pix(out_pix),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .done_pulse(done_pulse)
	);

endmodule

`default_nettype wire

//--- hdl/pixel_store.sv
`default_nettype none

module pixel_store
	import blend_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic [addr_w-1:0] dst,
	input  logic              out_valid,
	input  logic              out_last,
	input  logic [cnt_w-1:0]  out_index,
	input  pixel_t            out_pix,
	output logic              wr_en,
	output logic [addr_w-1:0] wr_addr,
	output logic [pix_w-1:0]  wr_data,
	output logic              done_pulse
);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_en      <= 1'b0;
			done_pulse <= 1'b0;
		end
		else
		begin
			wr_en      <= out_valid;             // One write per result
			done_pulse <= out_valid && out_last; // Same cycle as the final write
		end
	end

	always_ff @(posedge clk)
	begin
		if (out_valid)
		begin
			wr_addr <= dst + addr_w'(out_index);  // Destination region offset
			wr_data <= out_pix.raw;
		end
	end

	// Successive writes of a run, two cycles apart, never hit the same word
	a_wr_addr: assert property (@(posedge clk) disable iff (reset)
		wr_en && $past(wr_en, 2) |-> wr_addr != $past(wr_addr, 2));

endmodule

`default_nettype wire

//--- hdl/alpha_mix.sv
`default_nettype none

module alpha_mix
	import blend_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic [alpha_w-1:0] alpha,
	pix_pair_if.dst            pair,
	output logic               out_valid,
	output logic               out_last,
	output logic [cnt_w-1:0]   out_index,
	output pixel_t             out_pix
);

	logic [alpha_w:0]   inv_alpha;           // 16 - alpha, 1 to 16
	logic               v1;                  // Stage one valid
	logic               last1;
	logic [cnt_w-1:0]   idx1;
	logic [mix_w-1:0]   pa_r, pa_g, pa_b;    // A weighted by alpha
	logic [mix_w-1:0]   pb_r, pb_g, pb_b;    // B weighted by 16 - alpha
	logic [mix_w-1:0]   sum_r, sum_g, sum_b;

	assign inv_alpha = {1'b1, {alpha_w{1'b0}}} - {1'b0, alpha};

	assign sum_r = pa_r + pb_r;  // At most 255 * 16, no overflow
	assign sum_g = pa_g + pb_g;
	assign sum_b = pa_b + pb_b;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			v1        <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			v1        <= pair.valid;
			out_valid <= v1;
		end
	end

	always_ff @(posedge clk)
	begin
		pa_r  <= pair.a.rgb.r * alpha;  // Stage one, products
		pa_g  <= pair.a.rgb.g * alpha;
		pa_b  <= pair.a.rgb.b * alpha;
		pb_r  <= pair.b.rgb.r * inv_alpha;
		pb_g  <= pair.b.rgb.g * inv_alpha;
		pb_b  <= pair.b.rgb.b * inv_alpha;
		last1 <= pair.last;
		idx1  <= pair.index;
		out_pix.rgb.r <= sum_r[mix_w-1:alpha_w];  // Stage two, divide by 16
		out_pix.rgb.g <= sum_g[mix_w-1:alpha_w];
		out_pix.rgb.b <= sum_b[mix_w-1:alpha_w];
		out_last      <= last1;
		out_index     <= idx1;
	end

	// Fixed two-cycle latency from fetch to store
	a_mix_latency: assert property (@(posedge clk) disable iff (reset)
		out_valid == $past(pair.valid, 2));

endmodule

`default_nettype wire

//--- hdl/pixel_fetch.sv
`default_nettype none

module pixel_fetch
	import blend_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  logic [addr_w-1:0] src_a,
	input  logic [addr_w-1:0] src_b,
	input  logic [cnt_w-1:0]  count,
	output logic              rd_en,
	output logic [addr_w-1:0] rd_addr,
	input  logic [pix_w-1:0]  rd_data,
	pix_pair_if.src           pair
);

	logic             running;  // Reads in progress
	logic             phase;    // 0 reads A, 1 reads B
	logic [cnt_w-1:0] index;    // Current pixel
	logic             a_pend;   // A data arrives this cycle
	logic             is_last;  // Current index is the final one

	assign is_last = (index == count - 1'b1);
	assign rd_en   = running;
	assign rd_addr = (phase ? src_b : src_a) + addr_w'(index);

	assign pair.b.raw = rd_data;  // B is on the read bus when valid rises

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			running    <= 1'b0;
			phase      <= 1'b0;
			index      <= '0;
			a_pend     <= 1'b0;
			pair.valid <= 1'b0;
		end
		else
		begin
			a_pend     <= rd_en && !phase;
			pair.valid <= rd_en && phase;  // Pair leaves when B returns
			if (start && (count != '0))
			begin
				running <= 1'b1;
				phase   <= 1'b0;
				index   <= '0;
			end
			else if (running)
			begin
				phase <= !phase;
				if (phase)
				begin
					if (is_last)
						running <= 1'b0;  // Final B read issued
					else
						index <= index + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (a_pend)
			pair.a.raw <= rd_data;  // Hold A until its partner arrives
		if (rd_en && phase)
		begin
			pair.index <= index;
			pair.last  <= is_last;
		end
	end

	// Reads stay inside the programmed pixel range of a run
	a_rd_range: assert property (@(posedge clk) disable iff (reset)
		rd_en |-> (index < count));

endmodule

`default_nettype wire

//--- hdl/blend_regs.sv
`default_nettype none

module blend_regs
	import blend_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [apb_aw-1:0]  paddr,
	input  logic [apb_dw-1:0]  pwdata,
	output logic [apb_dw-1:0]  prdata,
	output logic               pready,
	output logic               pslverr,
	input  logic               done_pulse,
	output logic               start,
	output logic [alpha_w-1:0] alpha,
	output logic [addr_w-1:0]  src_a,
	output logic [addr_w-1:0]  src_b,
	output logic [addr_w-1:0]  dst,
	output logic [cnt_w-1:0]   count
);

	logic               access;     // APB access phase
	logic               wr_access;  // Write in access phase
	logic               mapped;     // Offset hits a register
	logic               start_ok;   // Start request accepted
	logic               busy;
	logic               done;       // Sticky until next start
	logic [alpha_w-1:0] cfg_alpha;  // Software copy of ctrl.alpha

	assign access    = psel && penable;
	assign wr_access = access && pwrite;
	assign pready    = access;  // No wait states
	assign pslverr   = access && !mapped;
	assign start_ok  = wr_access && (paddr == reg_ctrl) && pwdata[ctrl_start_bit] && !busy;

	always_comb
	begin
		prdata = '0;  // Unmapped offsets read zero
		mapped = 1'b1;
		case (paddr)
			reg_ctrl:   prdata[ctrl_alpha_lsb +: alpha_w] = cfg_alpha;  // Start reads back 0
			reg_src_a:  prdata = apb_dw'(src_a);
			reg_src_b:  prdata = apb_dw'(src_b);
			reg_dst:    prdata = apb_dw'(dst);
			reg_count:  prdata = apb_dw'(count);
			reg_status:
			begin
				prdata[stat_busy_bit] = busy;
				prdata[stat_done_bit] = done;
			end
			default:    mapped = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			start     <= 1'b0;
			busy      <= 1'b0;
			done      <= 1'b0;
			cfg_alpha <= '0;
			alpha     <= '0;
			src_a     <= '0;
			src_b     <= '0;
			dst       <= '0;
			count     <= '0;
		end
		else
		begin
			start <= start_ok;  // Pulse one cycle after the access
			if (wr_access && (paddr == reg_ctrl))
				cfg_alpha <= pwdata[ctrl_alpha_lsb +: alpha_w];
			if (start_ok)
				alpha <= pwdata[ctrl_alpha_lsb +: alpha_w];  // Frozen for the whole run
			if (wr_access && !busy)  // Addresses and count stay put during a run
			begin
				case (paddr)
					reg_src_a: src_a <= pwdata[addr_w-1:0];
					reg_src_b: src_b <= pwdata[addr_w-1:0];
					reg_dst:   dst   <= pwdata[addr_w-1:0];
					reg_count: count <= pwdata[cnt_w-1:0];
					default:   ;
				endcase
			end
			if (start_ok)
			begin
				busy <= 1'b1;
				done <= 1'b0;  // New run clears old done
			end
			else if (start && (count == '0))
			begin
				busy <= 1'b0;  // Empty run finishes at once
				done <= 1'b1;
			end
			else if (done_pulse)
			begin
				busy <= 1'b0;  // Last pixel written
				done <= 1'b1;
			end
		end
	end

	// Every access phase follows a setup phase of the same transfer
	a_apb_phase: assert property (@(posedge clk) disable iff (reset)
		penable |-> psel && $past(psel && !penable));

endmodule

`default_nettype wire

//--- hdl/pix_pair_if.sv
`default_nettype none

// Fetched A and B pixels travelling to the mixer, no handshake back
interface pix_pair_if
	import blend_pkg::*;
();

	logic             valid;  // One-cycle strobe per pair
	logic             last;   // Final pixel of the run
	logic [cnt_w-1:0] index;  // Pixel position in the image
	pixel_t           a;      // Pixel from image A
	pixel_t           b;      // Pixel from image B

	modport src (
		output valid, last, index, a, b
	);

	modport dst (
		input valid, last, index, a, b
	);

endinterface

`default_nettype wire

//--- hdl/blend_pkg.sv
`default_nettype none

package blend_pkg;

	localparam int addr_w  = 24;             // SRAM word address
	localparam int chan_w  = 8;              // One colour channel
	localparam int pix_w   = 3 * chan_w;     // Packed RGB pixel
	localparam int alpha_w = 4;              // Blend weight, 0 to 15
	localparam int cnt_w   = 16;             // Pixel count and index
	localparam int mix_w   = chan_w + alpha_w; // Channel product and sum

	localparam int apb_aw = 8;               // APB byte address
	localparam int apb_dw = 32;              // APB data bus

	localparam logic [apb_aw-1:0] reg_ctrl   = 8'h00; // Start and alpha
	localparam logic [apb_aw-1:0] reg_src_a  = 8'h04; // Base of image A
	localparam logic [apb_aw-1:0] reg_src_b  = 8'h08; // Base of image B
	localparam logic [apb_aw-1:0] reg_dst    = 8'h0C; // Base of output image
	localparam logic [apb_aw-1:0] reg_count  = 8'h10; // Pixels per run
	localparam logic [apb_aw-1:0] reg_status = 8'h14; // Busy and done

	localparam int ctrl_start_bit = 0;
	localparam int ctrl_alpha_lsb = 4;       // Alpha sits in ctrl[7:4]
	localparam int stat_busy_bit  = 0;
	localparam int stat_done_bit  = 1;

	typedef struct packed {
		logic [chan_w-1:0] r;               // Upper byte of the SRAM word
		logic [chan_w-1:0] g;
		logic [chan_w-1:0] b;               // Lower byte
	} rgb_t;

	typedef union packed {
		logic [pix_w-1:0] raw;              // Word as stored in the SRAM
		rgb_t             rgb;              // Channel view for the mixer
	} pixel_t;

endpackage

`default_nettype wire
